/* list.f */
+incdir+common
common/spi_proto_pkg.sv
common/spi_sys_pkg.sv
common/spi_cmd_if.sv
hw/spi_dispatch.sv
spi_master/spi_master.sv
hw/spi_collect.sv
hw/spi_subsys.sv
bench/tb_spi_subsys.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_spi_subsys
FILELIST ?= list.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_spi_subsys.sv */
`default_nettype none

`include "spi_params.svh"

module tb_spi_subsys
  import spi_proto_pkg::*, spi_sys_pkg::*;
();

  localparam int NCH    = `SPI_NUM_CHAN;
  localparam int NROWS  = 15;
  localparam int PERIOD = 4;

  logic                       clk;
  logic                       rst_n;
  logic [`SPI_CMD_WIDTH-1:0]  cmd_in;
  chan_idx_t                  cmd_chan;
  logic                       cmd_vld;
  logic                       cmd_rdy;
  logic [NCH-1:0]             sclk;
  logic [NCH-1:0]             cs_n;
  logic [NCH-1:0]             mosi;
  wire  [NCH-1:0]             miso;
  logic                       read_vld;
  logic [`SPI_READ_WIDTH-1:0] read_data;
  chan_idx_t                  read_chan;

  // Stimulus table, one command per row.
  chan_idx_t   row_chan [NROWS];
  logic [11:0] row_cmd  [NROWS];
  logic        row_read [NROWS];
  logic [7:0]  row_exp  [NROWS];
  int          row_wait [NROWS];
  logic        row_bad  [NROWS];
  int          nrows_built = 0;

  logic [7:0] mirror [NCH][8]; // Expected contents of each slave's bank.

  // Accepted rows per channel, oldest first.
  int         row_fifo [NCH][32];
  logic [4:0] fifo_wr  [NCH];
  logic [4:0] fifo_rd  [NCH];
  logic       frame_open [NCH];

  int err_count      = 0;
  int tests_passed   = 0;
  int tests_failed   = 0;
  int rows_done      = 0;
  int read_pulses    = 0;
  int reads_expected = 0;

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  spi_subsys i_spi_subsys (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_chan  (cmd_chan),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_chan (read_chan)
  );

  // ======================================================================
  // Reporting and table helpers
  // ======================================================================

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("[FAIL] t=%0t %s: got 'h%0h, expected 'h%0h", $time, name, got, exp);
    err_count++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    err_count++;
  endtask

  task automatic finish_row(input int r);
    rows_done++;
    if (row_bad[r])
      tests_failed++;
    else
      tests_passed++;
    $display("row %0d: %s ch%0d addr %0d data 'h%02h, waited %0d cycles: %s",
             r, row_read[r] ? "read " : "write", row_chan[r], row_cmd[r][10:8],
             row_exp[r], row_wait[r], row_bad[r] ? "failed" : "ok");
  endtask

  task automatic add_write(input chan_idx_t ch, input logic [2:0] addr,
                           input logic [7:0] data);
    row_chan[nrows_built] = ch;
    row_cmd[nrows_built]  = {OP_WRITE, addr, data};
    row_read[nrows_built] = 1'b0;
    row_exp[nrows_built]  = data;
    mirror[ch][addr]      = data;
    nrows_built++;
  endtask

  task automatic add_read(input chan_idx_t ch, input logic [2:0] addr);
    row_chan[nrows_built] = ch;
    row_cmd[nrows_built]  = {OP_READ, addr, 8'h00};
    row_read[nrows_built] = 1'b1;
    row_exp[nrows_built]  = mirror[ch][addr];
    nrows_built++;
    reads_expected++;
  endtask

  task automatic build_table();
    for (int c = 0; c < NCH; c++)
      for (int a = 0; a < 8; a++)
        mirror[c][a] = 8'(a * 8'h11);
    // Back to back reads of default contents on all channels.
    add_read(2'd0, 3'd2);
    add_read(2'd1, 3'd4);
    add_read(2'd2, 3'd6);
    add_read(2'd3, 3'd1);
    add_write(2'd0, 3'd3, 8'ha5);
    add_write(2'd1, 3'd3, 8'($urandom));
    add_read(2'd0, 3'd3);
    add_read(2'd1, 3'd3);
    add_write(2'd2, 3'd5, 8'($urandom));
    add_read(2'd3, 3'd0); // Goes out while channel 2 is still busy.
    add_read(2'd2, 3'd5);
    add_write(2'd3, 3'd0, 8'($urandom));
    add_read(2'd3, 3'd0);
    add_write(2'd1, 3'd7, 8'($urandom));
    add_read(2'd1, 3'd7);
  endtask

  // Holds one row on the host port until it is accepted.
  task automatic issue_row(input int r);
    chan_idx_t ch;
    int        waited;
    logic      accepted;
    ch       = row_chan[r];
    waited   = 0;
    accepted = 1'b0;
    cmd_in   = row_cmd[r];
    cmd_chan = ch;
    cmd_vld  = 1'b1;
    while (!accepted)
    begin
      @(negedge clk);
      if (cmd_rdy == frame_open[ch])
      begin
        report_problem($sformatf("cmd_rdy is %0b for channel %0d while it is %s",
                                 cmd_rdy, ch, frame_open[ch] ? "busy" : "idle"));
        row_bad[r] = 1'b1;
      end
      if (cmd_rdy)
        accepted = 1'b1;
      else
        waited++;
    end
    @(posedge clk);
    #1;
    cmd_vld             = 1'b0;
    frame_open[ch]      = 1'b1;
    row_wait[r]         = waited;
    row_fifo[ch][fifo_wr[ch]] = r;
    fifo_wr[ch]         = fifo_wr[ch] + 1'b1;
  endtask

  // ======================================================================
  // SPI slave models, one per channel
  // ======================================================================

  for (genvar g = 0; g < NCH; g++)
  begin : g_slave
    logic [7:0]  bank [8];
    logic [11:0] rx;
    logic [3:0]  hdr;
    logic        miso_q;
    int          nbits;

    assign miso[g] = miso_q;

    initial
    begin
      int r;
      miso_q = 1'b0;
      rx     = '0;
      hdr    = '0;
      for (int a = 0; a < 8; a++)
        bank[a] = 8'(a * 8'h11);
      forever
      begin
        @(negedge cs_n[g]);
        nbits = 0;
        @(posedge sclk[g] or posedge cs_n[g]);
        while (!cs_n[g])
        begin
          rx = {rx[10:0], mosi[g]};
          nbits++;
          if (nbits == `SPI_RD_HDR_BITS)
            hdr = rx[3:0];
          @(negedge sclk[g] or posedge cs_n[g]);
          if (!cs_n[g])
          begin
            if (hdr[3] == OP_READ && nbits >= `SPI_RD_HDR_BITS && nbits < 12)
              miso_q = bank[hdr[2:0]][11 - nbits]; // MSB first after the header.
            else
              miso_q = 1'b0;
            @(posedge sclk[g] or posedge cs_n[g]);
          end
        end
        // Frame ended on cs_n rising.
        frame_open[g] = 1'b0;
        if (fifo_rd[g] == fifo_wr[g])
        begin
          report_problem($sformatf("frame on channel %0d with no command issued", g));
        end
        else
        begin
          r = row_fifo[g][fifo_rd[g]];
          if (nbits != 12)
          begin
            report_problem($sformatf("channel %0d frame had %0d sclk edges instead of 12",
                                     g, nbits));
            row_bad[r] = 1'b1;
          end
          if (hdr != row_cmd[r][11:8])
          begin
            value_mismatch($sformatf("ch%0d frame header", g), 32'(hdr),
                           32'(row_cmd[r][11:8]));
            row_bad[r] = 1'b1;
          end
          if (!row_read[r])
          begin
            if (rx[7:0] != row_cmd[r][7:0])
            begin
              value_mismatch($sformatf("ch%0d mosi data", g), 32'(rx[7:0]),
                             32'(row_cmd[r][7:0]));
              row_bad[r] = 1'b1;
            end
            bank[hdr[2:0]] = rx[7:0];
            fifo_rd[g]     = fifo_rd[g] + 1'b1;
            finish_row(r);
          end
        end
      end
    end

    // sclk may only be high while cs_n is low.
    initial
    begin
      forever
      begin
        @(posedge sclk[g] or posedge cs_n[g]);
        if (sclk[g] === 1'b1 && cs_n[g] === 1'b1)
          report_problem($sformatf("sclk high on channel %0d with cs_n high", g));
      end
    end
  end

  // ======================================================================
  // Read return monitor
  // ======================================================================

  initial
  begin
    int r;
    forever
    begin
      @(negedge clk);
      if (read_vld)
      begin
        read_pulses++;
        if (fifo_rd[read_chan] == fifo_wr[read_chan])
        begin
          report_problem($sformatf("read_vld on channel %0d with no read outstanding",
                                   read_chan));
        end
        else
        begin
          r = row_fifo[read_chan][fifo_rd[read_chan]];
          if (!row_read[r])
          begin
            report_problem($sformatf("read_vld on channel %0d for write row %0d",
                                     read_chan, r));
            row_bad[r] = 1'b1;
          end
          else
          begin
            if (read_data !== row_exp[r])
            begin
              value_mismatch($sformatf("read_data (ch%0d, row %0d)", read_chan, r),
                             32'(read_data), 32'(row_exp[r]));
              row_bad[r] = 1'b1;
            end
            fifo_rd[read_chan] = fifo_rd[read_chan] + 1'b1;
            finish_row(r);
          end
        end
      end
    end
  end

  // ======================================================================
  // Main sequence
  // ======================================================================

  initial
  begin
    int errs_before_reset_check;
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_chan = '0;
    cmd_vld  = 1'b0;
    void'($urandom(32'h0e53_609a));
    for (int c = 0; c < NCH; c++)
    begin
      fifo_wr[c]    = '0;
      fifo_rd[c]    = '0;
      frame_open[c] = 1'b0;
    end
    for (int r = 0; r < NROWS; r++)
    begin
      row_bad[r]  = 1'b0;
      row_wait[r] = 0;
    end
    build_table();

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    errs_before_reset_check = err_count;
    if (cs_n !== {NCH{1'b1}})
      value_mismatch("cs_n", 32'(cs_n), 32'({NCH{1'b1}}));
    if (sclk !== '0)
      value_mismatch("sclk", 32'(sclk), 32'(0));
    if (mosi !== '0)
      value_mismatch("mosi", 32'(mosi), 32'(0));
    if (read_vld !== 1'b0)
      value_mismatch("read_vld", 32'(read_vld), 32'(0));
    if (cmd_rdy !== 1'b1)
      value_mismatch("cmd_rdy", 32'(cmd_rdy), 32'(1));
    if (err_count != errs_before_reset_check)
    begin
      tests_failed++;
      $display("reset values: failed");
    end
    else
    begin
      tests_passed++;
      $display("reset values: ok");
    end

    @(posedge clk);
    #1;
    for (int r = 0; r < NROWS; r++)
      issue_row(r);

    while (rows_done < NROWS)
      @(negedge clk);
    repeat (20) @(negedge clk); // Room for any stray read_vld.

    if (read_pulses != reads_expected)
      report_problem($sformatf("saw %0d read_vld pulses, expected %0d",
                               read_pulses, reads_expected));

    $display("%0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    #(PERIOD * (NROWS * 150 + 500));
    $display("Watchdog expired with %0d of %0d rows finished", rows_done, NROWS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/spi_subsys.sv */
`default_nettype none

`include "spi_params.svh"

module spi_subsys
  import spi_sys_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  // Host command side.
  input  wire logic [`SPI_CMD_WIDTH-1:0]  cmd_in,
  input  wire chan_idx_t                  cmd_chan,
  input  wire logic                       cmd_vld,
  output logic                            cmd_rdy,
  // One SPI bus per channel.
  output logic [`SPI_NUM_CHAN-1:0]        sclk,
  output logic [`SPI_NUM_CHAN-1:0]        cs_n,
  output logic [`SPI_NUM_CHAN-1:0]        mosi,
  input  wire logic [`SPI_NUM_CHAN-1:0]   miso,
  // Returned reads.
  output logic                            read_vld,
  output logic [`SPI_READ_WIDTH-1:0]      read_data,
  output chan_idx_t                       read_chan
);

  spi_cmd_if cmd_bus [`SPI_NUM_CHAN] ();

  spi_dispatch i_dispatch (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_chan (cmd_chan),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .ch       (cmd_bus)
  );

  for (genvar i = 0; i < `SPI_NUM_CHAN; i++)
  begin : g_chan
    spi_master i_master (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (cmd_bus[i]),
      .sclk  (sclk[i]),
      .cs_n  (cs_n[i]),
      .mosi  (mosi[i]),
      .miso  (miso[i])
    );
  end

  spi_collect i_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .ch        (cmd_bus),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_chan (read_chan)
  );

endmodule

`default_nettype wire

/* hw/spi_collect.sv */
`default_nettype none

`include "spi_params.svh"

module spi_collect
  import spi_sys_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  spi_cmd_if.coll                     ch [`SPI_NUM_CHAN],
  output logic                        read_vld,
  output logic [`SPI_READ_WIDTH-1:0]  read_data,
  output chan_idx_t                   read_chan
);

  localparam int NCH = `SPI_NUM_CHAN;
  localparam int RW  = `SPI_READ_WIDTH;

  collect_state_e state;
  chan_idx_t      ptr;
  logic [NCH-1:0] rd_done;
  logic [NCH-1:0] pending;
  logic [RW-1:0]  rd_data [NCH];
  logic [RW-1:0]  data_q  [NCH];

  for (genvar i = 0; i < NCH; i++)
  begin : g_chan
    // Command bit 11 low marks a read.
    assign rd_done[i] = ch[i].done & ~ch[i].cmd[`SPI_CMD_WIDTH-1];
    assign rd_data[i] = ch[i].rdata;

    a_no_overrun: assert property (
      @(posedge clk) disable iff (!rst_n) rd_done[i] |-> !pending[i]
    ) else $error("read on channel %0d finished before the last one was returned", i);
  end

  assign read_vld  = (state == CO_EMIT);
  assign read_data = data_q[ptr];
  assign read_chan = ptr;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= CO_SCAN;
      ptr     <= '0;
      pending <= '0;
    end
    else
    begin
      case (state)
        CO_SCAN:
        begin
          if (pending[ptr])
          begin
            state <= CO_EMIT;
          end
          else
          begin
            ptr <= chan_idx_t'(ptr + 1'b1);
          end
        end
        default:
        begin
          pending[ptr] <= 1'b0;
          ptr          <= chan_idx_t'(ptr + 1'b1); // Move on so others get a turn.
          state        <= CO_SCAN;
        end
      endcase
      for (int i = 0; i < NCH; i++)
      begin
        if (rd_done[i])
        begin
          pending[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NCH; i++)
    begin
      if (rd_done[i])
      begin
        data_q[i] <= rd_data[i];
      end
    end
  end

endmodule

`default_nettype wire

/* spi_master/spi_master.sv */
`default_nettype none

`include "spi_params.svh"

module spi_master
  import spi_proto_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  spi_cmd_if.chan   bus,
  output logic      sclk,
  output logic      cs_n,
  output logic      mosi,
  input  wire logic miso
);

  localparam int W     = `SPI_CMD_WIDTH;
  localparam int RW    = `SPI_READ_WIDTH;
  localparam int HDR   = `SPI_RD_HDR_BITS;
  localparam int DIV_W = $clog2(`SPI_HALF_DIV + 1);
  localparam int BIT_W = $clog2(W);

  localparam logic [W-1:0]     HDR_MASK = {{HDR{1'b1}}, {(W-HDR){1'b0}}};
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_HALF_DIV - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(W - 1);

  spi_state_e       state;
  spi_op_e          op_q;
  logic [W-1:0]     tx_q;
  logic [RW-1:0]    rx_q;
  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic             half_end;
  logic             load;
  logic             tx_step;
  logic             rx_step;

  assign half_end = (div_cnt == DIV_LAST);
  assign load     = (state == ST_IDLE) && bus.start;
  // mosi moves at the start of every low phase, i.e. after select and after each high phase.
  assign tx_step  = (state == ST_SELECT) ||
                    ((state == ST_HIGH) && half_end && (bit_cnt != BIT_LAST));
  assign rx_step  = (state == ST_LOW) && half_end; // Rising sclk.

  assign bus.busy  = (state != ST_IDLE) && (state != ST_DONE);
  assign bus.done  = (state == ST_DONE);
  assign bus.rdata = rx_q;

  // ======================================================================
  // Frame control
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= ST_IDLE;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end
    else
    begin
      div_cnt <= half_end ? '0 : div_cnt + 1'b1;
      if (tx_step)
      begin
        mosi <= tx_q[W-1];
      end
      case (state)
        ST_IDLE:
        begin
          div_cnt <= '0;
          if (bus.start)
          begin
            state <= ST_SELECT;
          end
        end
        ST_SELECT:
        begin
          cs_n    <= 1'b0;
          div_cnt <= '0;
          bit_cnt <= '0;
          state   <= ST_LOW;
        end
        ST_LOW:
        begin
          if (half_end)
          begin
            sclk  <= 1'b1;
            state <= ST_HIGH;
          end
        end
        ST_HIGH:
        begin
          if (half_end)
          begin
            sclk <= 1'b0;
            if (bit_cnt == BIT_LAST)
            begin
              mosi  <= 1'b0;
              state <= ST_DESELECT;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              state   <= ST_LOW;
            end
          end
        end
        ST_DESELECT:
        begin
          if (half_end)
          begin
            cs_n  <= 1'b1;
            state <= ST_DONE;
          end
        end
        default:
        begin
          state <= ST_IDLE; // ST_DONE lasts one cycle.
        end
      endcase
    end
  end

  // ======================================================================
  // Shift registers
  // ======================================================================

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      op_q <= spi_op_e'(bus.cmd[W-1]);
      // A read sends only its header and then holds mosi low.
      tx_q <= (spi_op_e'(bus.cmd[W-1]) == OP_READ) ? (bus.cmd & HDR_MASK) : bus.cmd;
    end
    else if (tx_step)
    begin
      tx_q <= tx_q << 1;
    end
    if (rx_step && (op_q == OP_READ))
    begin
      rx_q <= {rx_q[RW-2:0], miso}; // The last RW samples are the read data.
    end
  end

  a_cs_when_sclk: assert property (
    @(posedge clk) disable iff (!rst_n) sclk |-> !cs_n
  ) else $error("sclk high with cs_n deasserted");

  a_start_idle: assert property (
    @(posedge clk) disable iff (!rst_n) bus.start |-> !bus.busy
  ) else $error("start received while busy");

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) bus.done |=> !bus.done
  ) else $error("done longer than one cycle");

endmodule

`default_nettype wire

/* hw/spi_dispatch.sv */
`default_nettype none

`include "spi_params.svh"

module spi_dispatch
  import spi_sys_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic [`SPI_CMD_WIDTH-1:0] cmd_in,
  input  wire chan_idx_t                 cmd_chan,
  input  wire logic                      cmd_vld,
  output logic                           cmd_rdy,
  spi_cmd_if.disp                        ch [`SPI_NUM_CHAN]
);

  localparam int NCH = `SPI_NUM_CHAN;

  logic [NCH-1:0]            chan_busy;
  logic [NCH-1:0]            start_q;
  logic [`SPI_CMD_WIDTH-1:0] cmd_q [NCH];
  logic                      accept;

  // A channel counts as busy from the start pulse on, since the channel
  // itself only reports busy one cycle later.
  for (genvar i = 0; i < NCH; i++)
  begin : g_chan
    assign chan_busy[i] = ch[i].busy | start_q[i];
    assign ch[i].cmd    = cmd_q[i];
    assign ch[i].start  = start_q[i];

    a_no_start_when_busy: assert property (
      @(posedge clk) disable iff (!rst_n) ch[i].start |-> !ch[i].busy
    ) else $error("start sent to busy channel %0d", i);
  end

  assign cmd_rdy = ~chan_busy[cmd_chan];
  assign accept  = cmd_vld & cmd_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start_q <= '0;
    end
    else
    begin
      for (int i = 0; i < NCH; i++)
      begin
        start_q[i] <= accept && (cmd_chan == chan_idx_t'(i));
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q[cmd_chan] <= cmd_in;
    end
  end

endmodule

`default_nettype wire

/* common/spi_cmd_if.sv */
`default_nettype none

`include "spi_params.svh"

interface spi_cmd_if;

  logic [`SPI_CMD_WIDTH-1:0]  cmd;   // Held until the next command for this channel.
  logic                       start;
  logic                       busy;
  logic                       done;
  logic [`SPI_READ_WIDTH-1:0] rdata;

  modport disp (output cmd, output start, input busy);

  modport chan (input cmd, input start, output busy, output done, output rdata);

  // The collector also looks at cmd to tell reads from writes.
  modport coll (input cmd, input done, input rdata);

endinterface

`default_nettype wire

/* common/spi_sys_pkg.sv */
`default_nettype none

`include "spi_params.svh"

package spi_sys_pkg;

  // Channel number as seen by the host.
  typedef logic [$clog2(`SPI_NUM_CHAN)-1:0] chan_idx_t;

  // Read collector states.
  typedef enum logic {
    CO_SCAN = 1'b0,
    CO_EMIT = 1'b1
  } collect_state_e;

endpackage

`default_nettype wire

/* common/spi_proto_pkg.sv */
`default_nettype none

package spi_proto_pkg;

  // ======================================================================
  // Command opcode, taken from the top bit of the command word
  // ======================================================================

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  // ======================================================================
  // Channel shift states
  // ======================================================================

  // One frame walks SELECT, then LOW/HIGH once per bit, then DESELECT.
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_SELECT   = 3'd1, // cs_n falls here.
    ST_LOW      = 3'd2,
    ST_HIGH     = 3'd3,
    ST_DESELECT = 3'd4, // Trailing half-period with sclk low.
    ST_DONE     = 3'd5
  } spi_state_e;

endpackage

`default_nettype wire

/* common/spi_params.svh */
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// ======================================================================
// Subsystem sizing
// ======================================================================

// Command word is {op, addr[2:0], wdata[7:0]}.
`define SPI_CMD_WIDTH 12

`define SPI_READ_WIDTH 8

`define SPI_NUM_CHAN 4

// clk cycles per sclk half-period, so one bit takes twice this.
`define SPI_HALF_DIV 4

// Op bit plus address bits sent ahead of the read data.
`define SPI_RD_HDR_BITS 4

`endif
